// ==== ecc_115_top.f ====
rtl/ecc_pkg.sv
rtl/ecc_ingress.sv
rtl/ecc_check_gen.sv
rtl/ecc_syndrome_decode.sv
rtl/ecc_egress.sv
rtl/ecc_115_top.sv
tests/ecc_115_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ecc_115 testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module ecc_115_tb \
    -f ecc_115_top.f \
    -Mdir obj_dir -o ecc_115_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed, status $status"
    exit 1
fi

./obj_dir/ecc_115_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "^Simulation completed successfully$" "$SIM_LOG"; then
    exit 0
fi
exit 1

// ==== tests/ecc_115_tb.sv ====
`timescale 1ns/1ns

module ecc_115_tb;

    import ecc_pkg::*;

    localparam int          HALF_PERIOD = 20;
    localparam logic [31:0] LFSR_SEED   = 32'h81d2_8261;
    localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;
    localparam int          DIRECTED_N  = 10;
    localparam int          RANDOM_N    = 300;
    localparam int          DRAIN_LIMIT = 10;
    localparam int          SIM_LIMIT   = 100_000;
    localparam int          CW_W        = DATA_W + CHK_W;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [CHK_W-1:0]  check;
        logic              sbit;
        logic              dbit;
        logic              data_vld;  // cleared when data_out is unspecified
        logic [15:0]       tag;
    } exp_t;

    localparam exp_t IDLE_EXP = '{data: '0, check: '0, sbit: 1'b0, dbit: 1'b0,
                                  data_vld: 1'b1, tag: 16'd0};

    logic              clk;
    logic              arst_n;
    logic [DATA_W-1:0] data_in;
    logic [CHK_W-1:0]  parity_in;
    logic              bypass;
    logic [DATA_W-1:0] data_out;
    logic [CHK_W-1:0]  parity_out;
    logic              sbit_err;
    logic              dbit_err;

    exp_t        exp_in;
    exp_t        exp_q1;
    exp_t        exp_q2;
    logic [15:0] last_tag;
    logic [31:0] lfsr_state;
    int          pos_tbl [DATA_W];
    int          mismatch_cnt;
    int          other_cnt;

    ecc_115_top u_ecc_115_top (
        .clk        (clk),
        .arst_n     (arst_n),
        .data_in    (data_in),
        .parity_in  (parity_in),
        .bypass     (bypass),
        .data_out   (data_out),
        .parity_out (parity_out),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    always #HALF_PERIOD clk = ~clk;

    // two stages, same as ingress plus egress
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_q1 <= IDLE_EXP;
            exp_q2 <= IDLE_EXP;
        end else begin
            exp_q1 <= exp_in;
            exp_q2 <= exp_q1;
        end
    end

    // ----------------------------------------------------------------------
    // output checks
    // ----------------------------------------------------------------------
    data_out_a : assert property (@(posedge clk)
        !exp_q2.data_vld || data_out == exp_q2.data)
        else begin
            mismatch_cnt++;
            $display("mismatch at %0t: data_out expected %h got %h", $time,
                     $sampled(exp_q2.data), $sampled(data_out));
        end

    parity_out_a : assert property (@(posedge clk) parity_out == exp_q2.check)
        else begin
            mismatch_cnt++;
            $display("mismatch at %0t: parity_out expected %h got %h", $time,
                     $sampled(exp_q2.check), $sampled(parity_out));
        end

    sbit_err_a : assert property (@(posedge clk) sbit_err == exp_q2.sbit)
        else begin
            mismatch_cnt++;
            $display("mismatch at %0t: sbit_err expected %b got %b", $time,
                     $sampled(exp_q2.sbit), $sampled(sbit_err));
        end

    dbit_err_a : assert property (@(posedge clk) dbit_err == exp_q2.dbit)
        else begin
            mismatch_cnt++;
            $display("mismatch at %0t: dbit_err expected %b got %b", $time,
                     $sampled(exp_q2.dbit), $sampled(dbit_err));
        end

    // ----------------------------------------------------------------------
    // random source and reference encoder
    // ----------------------------------------------------------------------
    function automatic logic [127:0] take_bits(input int n);
        logic [127:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits[i] = lfsr_state[0];
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ LFSR_TAPS : lfsr_state >> 1;
        end
        return bits;
    endfunction

    function automatic int pick(input int limit);
        logic [127:0] bits;
        bits = take_bits(8);
        return int'(bits[7:0]) % limit;
    endfunction

    task automatic build_positions();
        int p;
        p = 1;
        for (int i = 0; i < DATA_W; i++) begin
            while ((p & (p - 1)) == 0) p++;  // powers of two hold check bits
            pos_tbl[i] = p;
            p++;
        end
    endtask

    function automatic logic [CHK_W-1:0] encode(input logic [DATA_W-1:0] d);
        logic [CHK_W-1:0] chk;
        int               p;
        chk = '0;
        for (int i = 0; i < DATA_W; i++) begin
            if (d[i]) begin
                p = pos_tbl[i];
                for (int k = 0; k < CHK_W - 1; k++) begin
                    if (p[k]) chk[k] = ~chk[k];
                end
                if ($countones(p[6:0]) % 2 == 0) chk[CHK_W-1] = ~chk[CHK_W-1];
            end
        end
        return chk;
    endfunction

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    task automatic send(input codeword_t cw, input logic byp, input exp_t e);
        @(negedge clk);
        last_tag  = last_tag + 16'd1;
        data_in   = cw.data;
        parity_in = cw.check;
        bypass    = byp;
        exp_in    = e;
        exp_in.tag = last_tag;
    endtask

    // kind 0 clean, 1 data flip, 2 check flip, 3 double flip, 4 bypass
    task automatic run_case(input int kind);
        logic [127:0] rnd;
        logic [DATA_W-1:0] orig;
        codeword_t    cw;
        logic         byp;
        exp_t         e;
        int           a;
        int           b;
        rnd = take_bits(DATA_W);
        orig = rnd[DATA_W-1:0];
        cw.data = orig;
        cw.check = encode(orig);
        byp = 1'b0;
        e = '0;
        e.data = orig;
        e.data_vld = 1'b1;
        case (kind)
            0: ;
            1: begin
                a = pick(DATA_W);
                cw.data[a] = ~cw.data[a];
                e.sbit = 1'b1;
            end
            2: begin
                a = pick(CHK_W);
                cw.check[a] = ~cw.check[a];
                e.sbit = 1'b1;
            end
            3: begin
                a = pick(CW_W);
                b = pick(CW_W - 1);
                if (b >= a) b++;  // distinct bits
                cw[a] = ~cw[a];
                cw[b] = ~cw[b];
                e.dbit = 1'b1;
                e.data_vld = 1'b0;
            end
            default: begin
                byp = 1'b1;
                a = pick(CW_W);
                cw[a] = ~cw[a];
                if (take_bits(1) != '0) begin
                    b = pick(CW_W - 1);
                    if (b >= a) b++;
                    cw[b] = ~cw[b];
                end
                e.data = cw.data;  // passes through untouched
            end
        endcase
        e.check = encode(cw.data);  // regenerated from what was received
        send(cw, byp, e);
    endtask

    task automatic wait_drain();
        int cnt;
        cnt = 0;
        while (exp_q2.tag != last_tag && cnt < DRAIN_LIMIT) begin
            @(posedge clk);
            cnt++;
        end
        if (exp_q2.tag != last_tag) begin
            other_cnt++;
            $display("last codeword never reached the output stage");
        end
        @(posedge clk);  // let the checks see the last result
        @(negedge clk);
    endtask

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        data_in      = '0;
        parity_in    = '0;
        bypass       = 1'b0;
        exp_in       = IDLE_EXP;
        last_tag     = '0;
        lfsr_state   = LFSR_SEED;
        mismatch_cnt = 0;
        other_cnt    = 0;
        build_positions();

        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        repeat (2) @(negedge clk);  // zero codeword still in flight

        for (int i = 0; i < DIRECTED_N; i++) begin
            run_case(i % 5);
        end
        // back to back mix, two codewords in flight every cycle
        for (int i = 0; i < RANDOM_N; i++) begin
            run_case(pick(5));
        end
        wait_drain();

        $display("errors: mismatch=%0d other=%0d", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #SIM_LIMIT;
        $display("timeout: the run did not finish in time");
        $display("errors: mismatch=%0d other=%0d", mismatch_cnt, other_cnt + 1);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== rtl/ecc_115_top.sv ====
`timescale 1ns/1ns

module ecc_115_top (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [ecc_pkg::DATA_W-1:0] data_in,
    input  logic [ecc_pkg::CHK_W-1:0]  parity_in,
    input  logic                       bypass,
    output logic [ecc_pkg::DATA_W-1:0] data_out,
    output logic [ecc_pkg::CHK_W-1:0]  parity_out,
    output logic                       sbit_err,
    output logic                       dbit_err
);

    import ecc_pkg::*;

    ingress_t         rx;
    logic [CHK_W-1:0] gen_check;
    logic [DATA_W-1:0] mask;
    err_class_t       err_class;
    result_t          result;

    // ------------------------------------------------------------------
    // pipeline
    // ------------------------------------------------------------------
    ecc_ingress u_ingress (
        .clk       (clk),
        .arst_n    (arst_n),
        .data_in   (data_in),
        .parity_in (parity_in),
        .bypass    (bypass),
        .rx        (rx)
    );

    ecc_check_gen u_check_gen (.rx(rx), .gen_check(gen_check));

    ecc_syndrome_decode u_syndrome_decode (
        .rx        (rx),
        .gen_check (gen_check),
        .mask      (mask),
        .err_class (err_class)
    );

    ecc_egress u_egress (
        .clk       (clk),
        .arst_n    (arst_n),
        .rx        (rx),
        .gen_check (gen_check),
        .mask      (mask),
        .err_class (err_class),
        .result    (result)
    );

    assign data_out   = result.data;
    assign parity_out = result.check;
    assign sbit_err   = result.sbit_err;
    assign dbit_err   = result.dbit_err;

endmodule

// ==== rtl/ecc_egress.sv ====
`timescale 1ns/1ns

module ecc_egress (
    input  logic                       clk,
    input  logic                       arst_n,
    input  ecc_pkg::ingress_t          rx,
    input  logic [ecc_pkg::CHK_W-1:0]  gen_check,
    input  logic [ecc_pkg::DATA_W-1:0] mask,
    input  ecc_pkg::err_class_t        err_class,
    output ecc_pkg::result_t           result
);

    import ecc_pkg::*;

    // ------------------------------------------------------------------
    // output register stage
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else begin
            result.data     <= rx.bypass ? rx.cw.data : rx.cw.data ^ mask;
            result.check    <= gen_check;  // parity_out follows data under bypass too
            result.sbit_err <= !rx.bypass && (err_class == ERR_SINGLE);
            result.dbit_err <= !rx.bypass && (err_class == ERR_DOUBLE);
        end
    end

    flags_excl_a : assert property (@(posedge clk) disable iff (!arst_n)
        !(result.sbit_err && result.dbit_err))
        else $error("sbit_err and dbit_err set together");

endmodule

// ==== rtl/ecc_syndrome_decode.sv ====
`timescale 1ns/1ns

module ecc_syndrome_decode (
    input  ecc_pkg::ingress_t          rx,
    input  logic [ecc_pkg::CHK_W-1:0]  gen_check,
    output logic [ecc_pkg::DATA_W-1:0] mask,
    output ecc_pkg::err_class_t        err_class
);

    import ecc_pkg::*;

    logic [CHK_W-1:0] syndrome;
    logic             chk_hit;  // exactly one check bit differs

    assign syndrome = rx.cw.check ^ gen_check;
    assign chk_hit  = (syndrome != '0) && ((syndrome & (syndrome - 1'b1)) == '0);

    // ------------------------------------------------------------------
    // data bit locator
    // ------------------------------------------------------------------
    for (genvar i = 0; i < DATA_W; i++) begin : g_loc
        localparam logic [CHK_W-1:0] COL = data_column(i);

        assign mask[i] = (syndrome == COL);
    end

    // ------------------------------------------------------------------
    // classification
    // ------------------------------------------------------------------
    always_comb begin
        if (syndrome == '0) begin
            err_class = ERR_NONE;
        end else if ((|mask) || chk_hit) begin
            err_class = ERR_SINGLE;  // data bit or check bit
        end else begin
            err_class = ERR_DOUBLE;  // even weight or unused column
        end
    end

    // columns from the package must be unique for the locator to work
    always_comb begin
        mask_onehot_a : assert final ($onehot0(mask) &&
                                      (mask == '0 || err_class == ERR_SINGLE))
            else $error("correction mask not one-hot or class not single");
    end

endmodule

// ==== rtl/ecc_check_gen.sv ====
`timescale 1ns/1ns

module ecc_check_gen (
    input  ecc_pkg::ingress_t         rx,
    output logic [ecc_pkg::CHK_W-1:0] gen_check
);

    import ecc_pkg::*;

    // per-bit share of the check vector
    logic [CHK_W-1:0] contrib [DATA_W];

    // ------------------------------------------------------------------
    // column selection
    // ------------------------------------------------------------------
    for (genvar i = 0; i < DATA_W; i++) begin : g_col
        localparam logic [CHK_W-1:0] COL = data_column(i);

        assign contrib[i] = {CHK_W{rx.cw.data[i]}} & COL;
    end

    // ------------------------------------------------------------------
    // xor tree
    // ------------------------------------------------------------------
    always_comb begin
        gen_check = '0;
        for (int i = 0; i < DATA_W; i++) begin
            gen_check ^= contrib[i];
        end
    end

endmodule

// ==== rtl/ecc_ingress.sv ====
`timescale 1ns/1ns

module ecc_ingress (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic [ecc_pkg::DATA_W-1:0] data_in,
    input  logic [ecc_pkg::CHK_W-1:0]  parity_in,
    input  logic                      bypass,
    output ecc_pkg::ingress_t          rx
);

    // ------------------------------------------------------------------
    // input register stage
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx <= '0;  // zero codeword decodes clean
        end else begin
            rx.cw.data  <= data_in;
            rx.cw.check <= parity_in;
            rx.bypass   <= bypass;
        end
    end

endmodule

// ==== rtl/ecc_pkg.sv ====
package ecc_pkg;

    // ------------------------------------------------------------------
    // code geometry
    // ------------------------------------------------------------------
    parameter int DATA_W = 115;
    parameter int HAM_W  = 7;
    parameter int CHK_W  = HAM_W + 1;  // hamming bits plus overall bit

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [CHK_W-1:0]  check;
    } codeword_t;

    typedef struct packed {
        codeword_t cw;
        logic      bypass;
    } ingress_t;

    typedef enum logic [1:0] {
        ERR_NONE   = 2'b00,
        ERR_SINGLE = 2'b01,
        ERR_DOUBLE = 2'b10
    } err_class_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;   // corrected or bypassed
        logic [CHK_W-1:0]  check;  // regenerated check bits
        logic              sbit_err;
        logic              dbit_err;
    } result_t;

    // ------------------------------------------------------------------
    // position helpers
    // ------------------------------------------------------------------
    // codeword position of data bit idx, skipping powers of two
    function automatic int unsigned data_pos(input int unsigned idx);
        int unsigned cnt;
        int unsigned pos;
        cnt = 0;
        pos = 0;
        for (int unsigned p = 3; p < 2 ** HAM_W; p++) begin
            if ((p & (p - 1)) != 0) begin
                if (cnt == idx) pos = p;
                cnt++;
            end
        end
        return pos;
    endfunction

    // column of the check matrix, odd weight for every data bit
    function automatic logic [CHK_W-1:0] data_column(input int unsigned idx);
        int unsigned pos;
        logic [CHK_W-1:0] col;
        pos = data_pos(idx);
        col[HAM_W-1:0] = pos[HAM_W-1:0];
        col[HAM_W] = ~^pos[HAM_W-1:0];  // set when position weight is even
        return col;
    endfunction

endpackage
